/* rv_pkg.sv */
package rv_pkg;

  // Datapath widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  // The one SYSTEM encoding the core accepts
  localparam logic [xlen-1:0] ecall_insn = 32'h0000_0073;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    op_lui      = 7'b0110111,
    op_auipc    = 7'b0010111,
    op_jal      = 7'b1101111,
    op_jalr     = 7'b1100111,
    op_branch   = 7'b1100011,
    op_load     = 7'b0000011,  // No data memory, decoded as illegal
    op_store    = 7'b0100011,  // Same
    op_imm      = 7'b0010011,
    op_reg      = 7'b0110011,
    op_misc_mem = 7'b0001111,  // FENCE
    op_system   = 7'b1110011
  } opcode_e;

  // Encoded as {funct7[5], funct3} so the decoder can map fields straight across
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_e;

  // Branch conditions, values equal to funct3
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_e;

  // Register write-back source
  typedef enum logic [1:0] {
    wb_alu,
    wb_imm_u,
    wb_pc_imm_u,
    wb_pc_plus4
  } wb_sel_e;

  // Next-PC rule
  typedef enum logic [2:0] {
    pc_seq,
    pc_branch,
    pc_jal,
    pc_jalr,
    pc_hold  // ECALL parks the core here
  } pc_sel_e;

  // What the ALU needs to know about one instruction
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;  // Second operand is dec.imm instead of rs2
    wb_sel_e wb_sel;
  } alu_ctrl_t;

  // One fully decoded instruction
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      reg_we;  // Already low for rd == x0
    alu_ctrl_t alu;
    pc_sel_e   pc_sel;
    branch_e   branch;
    word_t     imm;     // Sign-extended, format picked by opcode
    logic      ecall;
  } decoded_t;

endpackage

/* rv_decoder.sv */
module rv_decoder (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   imm_u;
  logic            writes_rd;  // Legal instruction of a writing class

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // Immediate formats, all sign-extended from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    writes_rd = 1'b0;

    dec             = '0;
    dec.rs1         = insn[19:15];
    dec.rs2         = insn[24:20];
    dec.rd          = insn[11:7];
    dec.alu.alu_op  = rv_pkg::alu_add;
    dec.alu.use_imm = 1'b0;
    dec.alu.wb_sel  = rv_pkg::wb_alu;
    dec.pc_sel      = rv_pkg::pc_seq;
    dec.branch      = rv_pkg::br_eq;
    dec.imm         = imm_i;
    dec.ecall       = 1'b0;

    case (opcode)
      rv_pkg::op_lui: begin
        writes_rd      = 1'b1;
        dec.imm        = imm_u;
        dec.alu.wb_sel = rv_pkg::wb_imm_u;
      end
      rv_pkg::op_auipc: begin
        writes_rd      = 1'b1;
        dec.imm        = imm_u;
        dec.alu.wb_sel = rv_pkg::wb_pc_imm_u;
      end
      rv_pkg::op_jal: begin
        writes_rd      = 1'b1;
        dec.imm        = imm_j;
        dec.alu.wb_sel = rv_pkg::wb_pc_plus4;
        dec.pc_sel     = rv_pkg::pc_jal;
      end
      rv_pkg::op_jalr: begin
        if (funct3 == 3'b000) begin  // Target sum comes from the ALU
          writes_rd      = 1'b1;
          dec.alu.wb_sel = rv_pkg::wb_pc_plus4;
          dec.pc_sel     = rv_pkg::pc_jalr;
        end
      end
      rv_pkg::op_branch: begin
        // funct3 010 and 011 are unassigned
        if (funct3[2:1] != 2'b01) begin
          dec.imm    = imm_b;
          dec.pc_sel = rv_pkg::pc_branch;
          dec.branch = rv_pkg::branch_e'(funct3);
        end
      end
      rv_pkg::op_imm: begin
        dec.alu.use_imm = 1'b1;
        // Shift immediates carry funct7 in the upper immediate bits
        if (funct3 == 3'b001) begin
          writes_rd = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          writes_rd = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          writes_rd = 1'b1;
        end
        dec.alu.alu_op = rv_pkg::alu_op_e'({(funct3 == 3'b101) && funct7[5], funct3});
      end
      rv_pkg::op_reg: begin
        writes_rd = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        dec.alu.alu_op = rv_pkg::alu_op_e'({funct7[5], funct3});
      end
      rv_pkg::op_misc_mem: begin
        // FENCE has nothing to order here
      end
      rv_pkg::op_system: begin
        if (insn == rv_pkg::ecall_insn) begin
          dec.ecall  = 1'b1;
          dec.pc_sel = rv_pkg::pc_hold;
        end
      end
      rv_pkg::op_load, rv_pkg::op_store: begin
        // No data memory, treated like any unknown encoding
      end
      default: begin
      end
    endcase

    dec.reg_we = writes_rd && (dec.rd != '0);  // x0 is never written
  end

endmodule

/* rv_regfile.sv */
module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  logic              we
);

  // x0 has no storage
  rv_pkg::word_t regs [1:rv_pkg::num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Combinational reads, new value visible only after the edge
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // The decoder must already drop writes aimed at x0
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst)
    we |-> (rd != '0)
  ) else $error("register write to x0 reached the register file");

endmodule

/* rv_alu.sv */
module rv_alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    sum
);

  rv_pkg::word_t op_b;
  rv_pkg::word_t result;
  logic [4:0]    shamt;

  assign op_b  = dec.alu.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];  // Upper bits ignored, also for SRAI

  // JALR target before bit 0 is cleared
  assign sum = rs1_data + dec.imm;

  always_comb begin
    case (dec.alu.alu_op)
      rv_pkg::alu_add: begin
        result = rs1_data + op_b;
      end
      rv_pkg::alu_sub: begin
        result = rs1_data - op_b;
      end
      rv_pkg::alu_sll: begin
        result = rs1_data << shamt;
      end
      rv_pkg::alu_slt: begin
        result = {{(rv_pkg::xlen-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      end
      rv_pkg::alu_sltu: begin
        result = {{(rv_pkg::xlen-1){1'b0}}, rs1_data < op_b};
      end
      rv_pkg::alu_xor: begin
        result = rs1_data ^ op_b;
      end
      rv_pkg::alu_srl: begin
        result = rs1_data >> shamt;
      end
      rv_pkg::alu_sra: begin
        result = $unsigned($signed(rs1_data) >>> shamt);  // Sign bit fills from the left
      end
      rv_pkg::alu_or: begin
        result = rs1_data | op_b;
      end
      rv_pkg::alu_and: begin
        result = rs1_data & op_b;
      end
      default: begin
        result = rs1_data + op_b;
      end
    endcase
  end

  // Write-back mux
  always_comb begin
    case (dec.alu.wb_sel)
      rv_pkg::wb_alu:      rd_data = result;
      rv_pkg::wb_imm_u:    rd_data = dec.imm;       // LUI
      rv_pkg::wb_pc_imm_u: rd_data = pc + dec.imm;  // AUIPC
      rv_pkg::wb_pc_plus4: rd_data = pc + 32'd4;    // Link value of JAL and JALR
      default:             rd_data = result;
    endcase
  end

endmodule

/* rv_pc_unit.sv */
module rv_pc_unit (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    jalr_target,
  output rv_pkg::word_t    pc
);

  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_next;
  logic          taken;

  assign pc_plus4 = pc + 32'd4;

  // Branch condition on the register operands
  always_comb begin
    case (dec.branch)
      rv_pkg::br_eq:  taken = (rs1_data == rs2_data);
      rv_pkg::br_ne:  taken = (rs1_data != rs2_data);
      rv_pkg::br_lt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::br_ge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::br_ltu: taken = (rs1_data < rs2_data);
      rv_pkg::br_geu: taken = (rs1_data >= rs2_data);
      default:        taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.pc_sel)
      rv_pkg::pc_seq: begin
        pc_next = pc_plus4;
      end
      rv_pkg::pc_branch: begin
        pc_next = taken ? (pc + dec.imm) : pc_plus4;
      end
      rv_pkg::pc_jal: begin
        pc_next = pc + dec.imm;
      end
      rv_pkg::pc_jalr: begin
        pc_next = {jalr_target[rv_pkg::xlen-1:1], 1'b0};
      end
      rv_pkg::pc_hold: begin
        pc_next = pc;  // Stays on ECALL until reset
      end
      default: begin
        pc_next = pc_plus4;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // Holds only while programs keep their branch, jump and JALR targets word aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc left word alignment");

endmodule

/* rv_core.sv */
module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,  // Word at pc, same cycle
  output rv_pkg::word_t pc,
  output logic          halt
);

  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    rd_data;
  rv_pkg::word_t    jalr_sum;

  rv_decoder decoder0 (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile regfile0 (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (dec.rd),
    .rd_data  (rd_data),
    .we       (dec.reg_we)
  );

  rv_alu alu0 (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_data  (rd_data),
    .sum      (jalr_sum)
  );

  rv_pc_unit pc_unit0 (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .jalr_target (jalr_sum),
    .pc          (pc)
  );

  // High for as long as ECALL sits at pc
  assign halt = dec.ecall;

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk,
  output logic rst,
  input  logic rst_req  // Starts a fresh reset sequence at the next rising edge
);

  localparam int half_period  = 50;
  localparam int reset_cycles = 4;

  int rst_left;  // Rising edges of reset still to come

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    rst_left = reset_cycles;
  end

  always @(posedge clk) begin
    if (rst_req) begin
      rst_left <= reset_cycles;
    end else if (rst_left > 0) begin
      rst_left <= rst_left - 1;
    end
  end

  assign rst = (rst_left != 0);

endmodule

/* rv_core_tb.sv */
module rv_core_tb;

  localparam int            prog_words = 256;
  localparam rv_pkg::word_t trap_addr  = 32'd1020;  // Last word, shared trap ECALL
  localparam rv_pkg::word_t ecall_word = 32'h0000_0073;
  localparam rv_pkg::word_t nop_word   = 32'h0000_0013;
  // About 750 program words over all tests plus reset and hold cycles, with headroom
  localparam int            max_cycles = 3000;

  logic          clk;
  logic          rst;
  logic          rst_req;
  rv_pkg::word_t insn;
  rv_pkg::word_t pc;
  logic          halt;

  rv_pkg::word_t prog [0:prog_words-1];  // Instruction memory, word index is pc / 4
  int            wp;                     // Next free program word
  int            errors;
  int            checks;
  int            cycle_count;
  integer        seed;
  string         test_name;
  rv_pkg::word_t halt_addr;              // Address of the pass ECALL

  tb_clock_gen clock_gen0 (
    .clk     (clk),
    .rst     (rst),
    .rst_req (rst_req)
  );

  rv_core dut0 (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .pc   (pc),
    .halt (halt)
  );

  // Instruction fetch answered on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      insn <= nop_word;
    end else begin
      insn <= prog[pc[9:2]];
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, %s never reached ECALL", cycle_count, test_name);
      $display("test failed");
      $finish;
    end
  end

  function automatic rv_pkg::word_t imm_word(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t reg_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input rv_pkg::word_t off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::word_t upper_word(input logic [6:0] opc, input logic [4:0] rd,
                                               input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::word_t jump_word(input logic [4:0] rd, input rv_pkg::word_t off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv_pkg::word_t cur_addr();
    return rv_pkg::word_t'(wp * 4);
  endfunction

  task automatic emit(input rv_pkg::word_t w);
    if (wp >= prog_words - 1) begin
      errors++;
      $display("Program of %s does not fit in instruction memory", test_name);
    end else begin
      prog[wp] = w;
      wp++;
    end
  endtask

  // LUI plus ADDI, upper part rounded for the sign-extended low 12 bits
  task automatic set_reg(input logic [4:0] rd, input rv_pkg::word_t value);
    rv_pkg::word_t upper;
    upper = value + 32'h800;
    emit(upper_word(rv_pkg::op_lui, rd, upper[31:12]));
    emit(imm_word(rv_pkg::op_imm, 3'b000, rd, rd, value[11:0]));
  endtask

  // Mismatch branches to the trap ECALL, x31 is scratch
  task automatic expect_reg(input logic [4:0] rs, input rv_pkg::word_t value);
    set_reg(31, value);
    emit(branch_word(rv_pkg::br_ne, rs, 31, trap_addr - cur_addr()));
  endtask

  task automatic jump_to_trap();
    emit(branch_word(rv_pkg::br_eq, 0, 0, trap_addr - cur_addr()));
  endtask

  task automatic imm_case(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rs1,
                          input rv_pkg::word_t expected);
    emit(imm_word(rv_pkg::op_imm, f3, 3, rs1, imm));
    expect_reg(3, expected);
  endtask

  task automatic reg_case(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rs1,
                          input logic [4:0] rs2, input rv_pkg::word_t expected);
    emit(reg_word(f7, f3, 3, rs1, rs2));
    expect_reg(3, expected);
  endtask

  // A taken branch skips the trap jump, a not-taken one would land on the trap
  task automatic branch_case(input logic [2:0] cond, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
    if (taken) begin
      emit(branch_word(cond, rs1, rs2, 32'd8));
      jump_to_trap();
    end else begin
      emit(branch_word(cond, rs1, rs2, trap_addr - cur_addr()));
    end
  endtask

  // Holds the core in reset while the new program is written
  task automatic new_program(input string name);
    test_name = name;
    @(negedge clk);
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    for (int i = 0; i < prog_words; i++) begin
      prog[i] = imm_word(rv_pkg::op_imm, 3'b000, 0, 0, 12'(i));  // ADDI x0, x0, index
    end
    prog[prog_words-1] = ecall_word;
    wp = 0;
  endtask

  task automatic run_program();
    halt_addr = cur_addr();
    emit(ecall_word);
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end
    checks += 2;
    if (pc !== 32'd0) begin
      errors++;
      $display("Fail %s pc after reset expected %h actual %h", test_name, 32'd0, pc);
    end
    if (halt !== 1'b0) begin
      errors++;
      $display("Fail %s halt after reset expected 0 actual %b", test_name, halt);
    end
    while (halt !== 1'b1) begin
      @(posedge clk);
    end
    checks++;
    if (pc !== halt_addr) begin
      errors++;
      $display("Fail %s pc at halt expected %h actual %h", test_name, halt_addr, pc);
    end
  endtask

  task automatic test_alu_ops();
    new_program("alu_ops");
    set_reg(1, 32'hFFFF_FFEC);  // -20
    set_reg(2, 32'd7);
    set_reg(4, 32'd63);         // Shift amount 31 in the low bits
    imm_case(3'b000, 12'd100, 1, 32'h0000_0050);
    imm_case(3'b010, 12'hFFB, 1, 32'd1);
    imm_case(3'b010, 12'h005, 2, 32'd0);
    imm_case(3'b011, 12'h005, 1, 32'd0);
    imm_case(3'b011, 12'hFFF, 2, 32'd1);  // Immediate compares as 0xFFFFFFFF
    imm_case(3'b100, 12'h0FF, 1, 32'hFFFF_FF13);
    imm_case(3'b110, 12'h003, 1, 32'hFFFF_FFEF);
    imm_case(3'b111, 12'hFF0, 1, 32'hFFFF_FFE0);
    imm_case(3'b001, 12'h004, 1, 32'hFFFF_FEC0);
    imm_case(3'b001, 12'h01F, 2, 32'h8000_0000);
    imm_case(3'b101, 12'h004, 1, 32'h0FFF_FFFE);
    imm_case(3'b101, 12'h01F, 1, 32'd1);
    imm_case(3'b101, 12'h402, 1, 32'hFFFF_FFFB);  // SRAI
    imm_case(3'b101, 12'h41F, 1, 32'hFFFF_FFFF);
    imm_case(3'b101, 12'h41F, 2, 32'd0);
    reg_case(7'h00, 3'b000, 1, 2, 32'hFFFF_FFF3);
    reg_case(7'h20, 3'b000, 1, 2, 32'hFFFF_FFE5);
    reg_case(7'h20, 3'b000, 2, 1, 32'h0000_001B);
    reg_case(7'h00, 3'b001, 1, 2, 32'hFFFF_F600);
    reg_case(7'h00, 3'b010, 1, 2, 32'd1);
    reg_case(7'h00, 3'b010, 2, 1, 32'd0);
    reg_case(7'h00, 3'b011, 1, 2, 32'd0);
    reg_case(7'h00, 3'b011, 2, 1, 32'd1);
    reg_case(7'h00, 3'b100, 1, 2, 32'hFFFF_FFEB);
    reg_case(7'h00, 3'b101, 1, 2, 32'h01FF_FFFF);
    reg_case(7'h20, 3'b101, 1, 2, 32'hFFFF_FFFF);
    reg_case(7'h00, 3'b110, 1, 2, 32'hFFFF_FFEF);
    reg_case(7'h00, 3'b111, 1, 2, 32'd4);
    reg_case(7'h00, 3'b001, 2, 4, 32'h8000_0000);
    reg_case(7'h00, 3'b101, 1, 4, 32'd1);
    reg_case(7'h20, 3'b101, 1, 4, 32'hFFFF_FFFF);
    run_program();
  endtask

  task automatic test_reset_state();
    new_program("reset_state");
    for (int r = 1; r < rv_pkg::num_regs; r++) begin
      emit(branch_word(rv_pkg::br_ne, 5'(r), 0, trap_addr - cur_addr()));
    end
    emit(branch_word(rv_pkg::br_eq, 5, 0, 32'd8));
    emit(ecall_word);  // Local trap, reached only if BEQ falls through
    run_program();
  endtask

  task automatic test_branches();
    rv_pkg::word_t loop_addr;
    new_program("branches");
    set_reg(1, 32'hFFFF_FFFF);
    set_reg(2, 32'd1);
    set_reg(3, 32'd1);
    branch_case(rv_pkg::br_eq, 2, 3, 1'b1);
    branch_case(rv_pkg::br_eq, 1, 2, 1'b0);
    branch_case(rv_pkg::br_ne, 1, 2, 1'b1);
    branch_case(rv_pkg::br_ne, 2, 3, 1'b0);
    branch_case(rv_pkg::br_lt, 1, 2, 1'b1);  // -1 < 1 signed
    branch_case(rv_pkg::br_lt, 2, 1, 1'b0);
    branch_case(rv_pkg::br_lt, 2, 3, 1'b0);
    branch_case(rv_pkg::br_ge, 2, 1, 1'b1);
    branch_case(rv_pkg::br_ge, 1, 2, 1'b0);
    branch_case(rv_pkg::br_ge, 2, 3, 1'b1);
    branch_case(rv_pkg::br_ltu, 2, 1, 1'b1);  // 1 < 0xFFFFFFFF unsigned
    branch_case(rv_pkg::br_ltu, 1, 2, 1'b0);
    branch_case(rv_pkg::br_geu, 1, 2, 1'b1);
    branch_case(rv_pkg::br_geu, 2, 1, 1'b0);
    branch_case(rv_pkg::br_geu, 2, 3, 1'b1);
    // Backward branch loop, three passes
    emit(imm_word(rv_pkg::op_imm, 3'b000, 4, 0, 12'd3));
    loop_addr = cur_addr();
    emit(imm_word(rv_pkg::op_imm, 3'b000, 4, 4, 12'hFFF));
    emit(imm_word(rv_pkg::op_imm, 3'b000, 5, 5, 12'd1));
    emit(branch_word(rv_pkg::br_ne, 4, 0, loop_addr - cur_addr()));
    expect_reg(4, 32'd0);
    expect_reg(5, 32'd3);
    run_program();
  endtask

  task automatic test_jumps();
    rv_pkg::word_t p;
    new_program("jumps");
    p = cur_addr();
    emit(jump_word(5, 32'd8));
    jump_to_trap();
    expect_reg(5, p + 32'd4);
    p = cur_addr();
    set_reg(6, p + 32'd16);
    emit(imm_word(rv_pkg::op_jalr, 3'b000, 7, 6, 12'd1));  // Odd target p + 17
    jump_to_trap();
    expect_reg(7, p + 32'd12);
    emit(upper_word(rv_pkg::op_lui, 8, 20'hABCDE));
    expect_reg(8, 32'hABCD_E000);
    p = cur_addr();
    emit(upper_word(rv_pkg::op_auipc, 9, 20'h12345));
    expect_reg(9, p + 32'h1234_5000);
    emit(imm_word(rv_pkg::op_imm, 3'b000, 0, 0, 12'd5));
    emit(upper_word(rv_pkg::op_lui, 0, 20'hFFFFF));
    emit(jump_word(0, 32'd4));
    expect_reg(0, 32'd0);
    // FENCE and a load both leave x11 alone
    set_reg(11, 32'h55);
    emit(32'h0FF0_000F);
    emit(imm_word(rv_pkg::op_load, 3'b010, 11, 0, 12'd0));
    expect_reg(11, 32'h55);
    run_program();
  endtask

  task automatic test_random(input string name, input int pairs);
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    new_program(name);
    for (int k = 0; k < pairs; k++) begin
      a = $random(seed);
      b = $random(seed);
      set_reg(1, a);
      set_reg(2, b);
      reg_case(7'h00, 3'b000, 1, 2, a + b);
      reg_case(7'h20, 3'b000, 1, 2, a - b);
      reg_case(7'h00, 3'b100, 1, 2, a ^ b);
      reg_case(7'h00, 3'b010, 1, 2, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      reg_case(7'h00, 3'b011, 1, 2, (a < b) ? 32'd1 : 32'd0);
    end
    run_program();
  endtask

  task automatic test_halt_hold();
    new_program("halt_hold");
    emit(imm_word(rv_pkg::op_imm, 3'b000, 1, 0, 12'd1));
    run_program();
    repeat (10) begin
      @(posedge clk);
      checks += 2;
      if (pc !== halt_addr) begin
        errors++;
        $display("Fail %s held pc expected %h actual %h", test_name, halt_addr, pc);
      end
      if (halt !== 1'b1) begin
        errors++;
        $display("Fail %s held halt expected 1 actual %b", test_name, halt);
      end
    end
  endtask

  initial begin
    rst_req     = 1'b0;
    insn        = nop_word;
    errors      = 0;
    checks      = 0;
    cycle_count = 0;
    seed        = 64454;
    wp          = 0;
    test_name   = "startup";
    halt_addr   = '0;

    test_alu_ops();
    test_reset_state();  // Runs after registers were written
    test_branches();
    test_jumps();
    test_random("random_a", 10);
    test_random("random_b", 10);
    test_halt_hold();

    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_pc_unit.sv
rv_core.sv
tb_clock_gen.sv
rv_core_tb.sv
